//--- cpu_pkg.sv
package cpu_pkg;

    localparam int addr_width = 6;
    localparam int data_width = 16;
    localparam int reg_count  = 8;                 // Words 0..7 double as registers
    localparam int reg_bits   = $clog2(reg_count);

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [data_width-1:0] data_t;
    typedef logic [3:0]            opcode_t;
    typedef logic [reg_bits:0]     operand_t;      // Indirect flag on top, register number below

    localparam addr_t prog_start = addr_t'(8);     // First instruction, PC after reset

    localparam opcode_t op_mov  = 4'h0;
    localparam opcode_t op_add  = 4'h1;
    localparam opcode_t op_sub  = 4'h2;
    localparam opcode_t op_mul  = 4'h3;
    localparam opcode_t op_div  = 4'h4;
    localparam opcode_t op_in   = 4'h7;
    localparam opcode_t op_out  = 4'h8;
    localparam opcode_t op_stop = 4'hf;

    // Control phases
    localparam logic [1:0] ph_fetch   = 2'd0;
    localparam logic [1:0] ph_operand = 2'd1;
    localparam logic [1:0] ph_exec    = 2'd2;
    localparam logic [1:0] ph_halted  = 2'd3;

    // Operand field select, also the order of the operand phases
    localparam logic [1:0] sel_x    = 2'd0;
    localparam logic [1:0] sel_y    = 2'd1;
    localparam logic [1:0] sel_z    = 2'd2;
    localparam logic [1:0] sel_done = 2'd3;

    // A memory word is either an instruction or data / pointer
    typedef union packed {
        struct packed {
            opcode_t  opc;
            operand_t opx;
            operand_t opy;
            operand_t opz;
        } instr;
        data_t word;                               // Pointer uses the low addr_width bits
    } mem_word_u;

    // Returns {uses_x, uses_y, uses_z}
    function automatic logic [2:0] op_mask(input opcode_t op);
        case (op)
            op_mov:         return 3'b101;
            op_add, op_sub: return 3'b111;
            op_mul, op_div: return 3'b000;         // Decoded as no operation
            op_in:          return 3'b001;
            op_out:         return 3'b100;
            default:        return 3'b000;         // STOP and unassigned codes
        endcase
    endfunction

endpackage

//--- cpu_control.sv
`timescale 1ns/100ps

module cpu_control (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::mem_word_u ir,
    input  cpu_pkg::mem_word_u mdr,
    input  logic               control,
    output logic               mar_from_pc,
    output logic               mar_from_field,
    output logic               mar_from_mdr,
    output logic               bus_read,
    output logic               mdr_load,
    output logic               ir_load,
    output logic               pc_inc,
    output logic               x_load,
    output logic               y_load,
    output logic               z_from_field,
    output logic               z_from_mdr,
    output logic               write_result,
    output logic               out_load,
    output logic               halt,
    output logic [1:0]         field_sel
);

    logic [1:0] phase, phase_next;
    logic [1:0] opnd, opnd_next;      // Operand currently being resolved
    logic [2:0] step, step_next;
    logic [2:0] mask;                 // {uses_x, uses_y, uses_z} of the instruction in IR
    logic       used;
    logic       ind;
    logic       load_val;             // Operand value sits in MDR
    logic       advance;              // Move on to the next operand

    assign field_sel = opnd;

    // Mask bit and indirect flag of the current operand
    always_comb begin
        case (opnd)
            cpu_pkg::sel_x: begin
                used = mask[2];
                ind  = ir.instr.opx[cpu_pkg::reg_bits];
            end
            cpu_pkg::sel_y: begin
                used = mask[1];
                ind  = ir.instr.opy[cpu_pkg::reg_bits];
            end
            default: begin
                used = mask[0];
                ind  = ir.instr.opz[cpu_pkg::reg_bits];
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= cpu_pkg::ph_fetch;
            opnd  <= cpu_pkg::sel_x;
            step  <= '0;
            mask  <= '0;
        end else begin
            phase <= phase_next;
            opnd  <= opnd_next;
            step  <= step_next;
            if (ir_load)
                mask <= cpu_pkg::op_mask(mdr.instr.opc);  // Decode as the word enters IR
        end
    end

    always_comb begin
        mar_from_pc    = 1'b0;
        mar_from_field = 1'b0;
        mar_from_mdr   = 1'b0;
        bus_read       = 1'b0;
        mdr_load       = 1'b0;
        ir_load        = 1'b0;
        pc_inc         = 1'b0;
        z_from_field   = 1'b0;
        z_from_mdr     = 1'b0;
        write_result   = 1'b0;
        out_load       = 1'b0;
        halt           = 1'b0;
        load_val       = 1'b0;
        advance        = 1'b0;
        phase_next     = phase;
        opnd_next      = opnd;
        step_next      = step;

        case (phase)
            cpu_pkg::ph_fetch: begin
                case (step)
                    3'd0: mar_from_pc = 1'b1;
                    3'd1: bus_read    = 1'b1;
                    3'd2: mdr_load    = 1'b1;
                    default: begin
                        ir_load = 1'b1;
                        pc_inc  = 1'b1;
                    end
                endcase
                if (step == 3'd3) begin
                    phase_next = cpu_pkg::ph_operand;
                    opnd_next  = cpu_pkg::sel_x;
                    step_next  = '0;
                end else begin
                    step_next = step + 3'd1;
                end
            end

            cpu_pkg::ph_operand: begin
                if (opnd == cpu_pkg::sel_done) begin
                    phase_next = cpu_pkg::ph_exec;   // Done cycle
                    step_next  = '0;
                end else begin
                    case (step)
                        3'd0: begin
                            if (!used) begin
                                advance = 1'b1;
                            end else if (opnd == cpu_pkg::sel_z && !ind) begin
                                z_from_field = 1'b1;  // Direct Z is the register number
                                advance      = 1'b1;
                            end else begin
                                mar_from_field = 1'b1;
                                step_next      = 3'd1;
                            end
                        end
                        3'd1, 3'd4: begin
                            bus_read  = 1'b1;
                            step_next = step + 3'd1;
                        end
                        3'd2, 3'd5: begin
                            mdr_load  = 1'b1;
                            step_next = step + 3'd1;
                        end
                        3'd3: begin
                            if (opnd == cpu_pkg::sel_z) begin
                                z_from_mdr = 1'b1;    // Pointer held in the register
                                advance    = 1'b1;
                            end else if (ind) begin
                                mar_from_mdr = 1'b1;
                                step_next    = 3'd4;
                            end else begin
                                load_val = 1'b1;
                            end
                        end
                        default: load_val = 1'b1;     // Indirect value arrived
                    endcase
                end
            end

            cpu_pkg::ph_exec: begin
                if (step == 3'd0) begin
                    case (ir.instr.opc)
                        cpu_pkg::op_mov, cpu_pkg::op_add, cpu_pkg::op_sub: begin
                            write_result = 1'b1;
                            step_next    = 3'd1;
                        end
                        cpu_pkg::op_in: begin
                            if (control) begin          // Otherwise keep waiting
                                write_result = 1'b1;
                                step_next    = 3'd1;
                            end
                        end
                        cpu_pkg::op_out: begin
                            out_load   = 1'b1;
                            phase_next = cpu_pkg::ph_fetch;
                        end
                        cpu_pkg::op_stop: begin
                            halt       = 1'b1;
                            phase_next = cpu_pkg::ph_halted;
                        end
                        default: phase_next = cpu_pkg::ph_fetch;
                    endcase
                end else begin
                    phase_next = cpu_pkg::ph_fetch;   // Write is on the bus now
                    step_next  = '0;
                end
            end

            default: ;  // Halted until reset
        endcase

        x_load = load_val && (opnd == cpu_pkg::sel_x);
        y_load = load_val && (opnd == cpu_pkg::sel_y);
        if (load_val || advance) begin
            opnd_next = opnd + 2'd1;
            step_next = '0;
        end
    end

endmodule

//--- cpu_datapath.sv
`timescale 1ns/100ps

module cpu_datapath (
    input  logic               clk,
    input  logic               rst_n,
    input  cpu_pkg::data_t     mem,
    input  cpu_pkg::data_t     in,
    input  logic               mar_from_pc,
    input  logic               mar_from_field,
    input  logic               mar_from_mdr,
    input  logic               bus_read,
    input  logic               mdr_load,
    input  logic               ir_load,
    input  logic               pc_inc,
    input  logic               x_load,
    input  logic               y_load,
    input  logic               z_from_field,
    input  logic               z_from_mdr,
    input  logic               write_result,
    input  logic               out_load,
    input  logic               halt,
    input  logic [1:0]         field_sel,
    output cpu_pkg::mem_word_u ir,
    output cpu_pkg::mem_word_u mdr,
    output cpu_pkg::addr_t     addr,
    output logic               we,
    output cpu_pkg::data_t     data,
    output cpu_pkg::data_t     out,
    output logic               status,
    output cpu_pkg::addr_t     pc
);

    cpu_pkg::addr_t   mar;
    cpu_pkg::data_t   x;
    cpu_pkg::data_t   y;
    cpu_pkg::addr_t   z;              // Destination address
    cpu_pkg::operand_t field_op;
    cpu_pkg::addr_t   field_addr;     // Register number as a memory address
    cpu_pkg::addr_t   mdr_ptr;
    cpu_pkg::data_t   result;

    always_comb begin
        case (field_sel)
            cpu_pkg::sel_x: field_op = ir.instr.opx;
            cpu_pkg::sel_y: field_op = ir.instr.opy;
            default:        field_op = ir.instr.opz;
        endcase
    end

    assign field_addr = cpu_pkg::addr_t'(field_op[cpu_pkg::reg_bits-1:0]);
    assign mdr_ptr    = mdr.word[cpu_pkg::addr_width-1:0];

    // Result of the instruction in IR
    always_comb begin
        case (ir.instr.opc)
            cpu_pkg::op_add: result = x + y;   // Wraps modulo 2^16
            cpu_pkg::op_sub: result = x - y;
            cpu_pkg::op_in:  result = in;
            default:         result = x;       // MOV
        endcase
    end

    always_ff @(posedge clk) begin
        if (mar_from_pc)
            mar <= pc;
        else if (mar_from_field)
            mar <= field_addr;
        else if (mar_from_mdr)
            mar <= mdr_ptr;

        if (mdr_load)
            mdr.word <= mem;
        if (ir_load)
            ir <= mdr;
        if (x_load)
            x <= mdr.word;
        if (y_load)
            y <= mdr.word;

        if (z_from_field)
            z <= field_addr;
        else if (z_from_mdr)
            z <= mdr_ptr;

        if (write_result)
            data <= result;
    end

    // Bus and status outputs lag their strobes by one cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc     <= cpu_pkg::prog_start;
            addr   <= '0;
            we     <= 1'b0;
            out    <= '0;
            status <= 1'b0;
        end else begin
            if (pc_inc)
                pc <= pc + cpu_pkg::addr_t'(1);
            we <= write_result;
            if (bus_read)
                addr <= mar;
            else if (write_result)
                addr <= z;
            if (out_load)
                out <= x;
            if (halt)
                status <= 1'b1;   // Sticky until reset
        end
    end

endmodule

//--- cpu_top.sv
`timescale 1ns/100ps

module cpu_top (
    input  logic           clk,
    input  logic           rst_n,
    input  cpu_pkg::data_t mem,
    input  cpu_pkg::data_t in,
    input  logic           control,
    output logic           status,
    output logic           we,
    output cpu_pkg::addr_t addr,
    output cpu_pkg::data_t data,
    output cpu_pkg::data_t out,
    output cpu_pkg::addr_t pc
);

    cpu_pkg::mem_word_u ir;
    cpu_pkg::mem_word_u mdr;
    logic               mar_from_pc;
    logic               mar_from_field;
    logic               mar_from_mdr;
    logic               bus_read;
    logic               mdr_load;
    logic               ir_load;
    logic               pc_inc;
    logic               x_load;
    logic               y_load;
    logic               z_from_field;
    logic               z_from_mdr;
    logic               write_result;
    logic               out_load;
    logic               halt;
    logic [1:0]         field_sel;

    cpu_control cpu_control_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ir             (ir),
        .mdr            (mdr),
        .control        (control),
        .mar_from_pc    (mar_from_pc),
        .mar_from_field (mar_from_field),
        .mar_from_mdr   (mar_from_mdr),
        .bus_read       (bus_read),
        .mdr_load       (mdr_load),
        .ir_load        (ir_load),
        .pc_inc         (pc_inc),
        .x_load         (x_load),
        .y_load         (y_load),
        .z_from_field   (z_from_field),
        .z_from_mdr     (z_from_mdr),
        .write_result   (write_result),
        .out_load       (out_load),
        .halt           (halt),
        .field_sel      (field_sel)
    );

    cpu_datapath cpu_datapath_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .mem            (mem),
        .in             (in),
        .mar_from_pc    (mar_from_pc),
        .mar_from_field (mar_from_field),
        .mar_from_mdr   (mar_from_mdr),
        .bus_read       (bus_read),
        .mdr_load       (mdr_load),
        .ir_load        (ir_load),
        .pc_inc         (pc_inc),
        .x_load         (x_load),
        .y_load         (y_load),
        .z_from_field   (z_from_field),
        .z_from_mdr     (z_from_mdr),
        .write_result   (write_result),
        .out_load       (out_load),
        .halt           (halt),
        .field_sel      (field_sel),
        .ir             (ir),
        .mdr            (mdr),
        .addr           (addr),
        .we             (we),
        .data           (data),
        .out            (out),
        .status         (status),
        .pc             (pc)
    );

endmodule

//--- cpu_props.sv
`timescale 1ns/100ps

module cpu_props (
    input logic           clk,
    input logic           rst_n,
    input logic           we,
    input logic           status,
    input cpu_pkg::addr_t pc
);

    int fails = 0;    // Failed assertions so far

    we_low_in_reset: assert property (@(posedge clk) !rst_n |-> !we)
        else begin
            fails++;
            $error("we high while reset is asserted");
        end

    we_single_cycle: assert property (@(posedge clk) disable iff (!rst_n) we |=> !we)
        else begin
            fails++;
            $error("we high for two cycles in a row");
        end

    // Halt is sticky until reset
    status_sticky: assert property (@(posedge clk) disable iff (!rst_n) status |=> status)
        else begin
            fails++;
            $error("status dropped without reset");
        end

    pc_frozen: assert property (@(posedge clk) disable iff (!rst_n) status |=> $stable(pc))
        else begin
            fails++;
            $error("pc moved after the CPU halted");
        end

endmodule

//--- cpu_tb.sv
`timescale 1ns/100ps

module cpu_tb;

    localparam int             n_cases   = 16;
    localparam int             max_delay = 35;           // Longest wait before control rises
    localparam int             mem_words = 1 << cpu_pkg::addr_width;
    localparam time            period    = 40ns;
    localparam time            limit     = n_cases * (32 + max_delay) * period;
    localparam cpu_pkg::addr_t tgt_addr  = 6'd40;        // Pointer target word
    localparam cpu_pkg::data_t stop_word = 16'hf000;

    logic           clk;
    logic           rst_n;
    cpu_pkg::data_t mem;
    cpu_pkg::data_t in_data;
    logic           control;
    logic           status;
    logic           we;
    cpu_pkg::addr_t addr;
    cpu_pkg::data_t data;
    cpu_pkg::data_t out;
    cpu_pkg::addr_t pc;

    cpu_pkg::data_t mem_model [mem_words];
    cpu_pkg::data_t exp_mem   [mem_words];
    cpu_pkg::data_t tab_instr [n_cases];
    cpu_pkg::data_t tab_regs  [n_cases][cpu_pkg::reg_count];
    cpu_pkg::data_t tab_tgt   [n_cases];
    int             tab_delay [n_cases];
    cpu_pkg::data_t exp_out;
    int             exp_writes;
    int             writes;
    int             n_added;
    int             errors;
    int             checks;
    int             props_fails;
    logic           ctrl_prev;
    logic           in_case;
    integer         seed = 32'ha1543529;

    cpu_top cpu_top_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem     (mem),
        .in      (in_data),
        .control (control),
        .status  (status),
        .we      (we),
        .addr    (addr),
        .data    (data),
        .out     (out),
        .pc      (pc)
    );

    bind cpu_top cpu_props cpu_props_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .we     (we),
        .status (status),
        .pc     (pc)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        #(limit);
        $display("Run did not finish within %0t, the DUT seems to be stuck", limit);
        $display("Something failed");
        $finish;
    end

    // Memory with asynchronous read, plus write monitor
    assign mem = mem_model[addr];

    always @(posedge clk) begin
        if (we === 1'b1) begin
            mem_model[addr] = data;
            writes = writes + 1;
            if (in_case && ctrl_prev !== 1'b1) begin
                errors = errors + 1;
                $display("IN wrote memory before control was seen high");
            end
        end
        ctrl_prev = control;
    end

    task automatic check_word(input string name, input cpu_pkg::data_t got,
                              input cpu_pkg::data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input cpu_pkg::addr_t got,
                              input cpu_pkg::addr_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s got %h expected %h", name, got, exp);
        end
    endtask

    // Words 0 and 1 vary, r2 and r3 are pointers
    task automatic add_case(input cpu_pkg::data_t instr, input cpu_pkg::data_t a,
                            input cpu_pkg::data_t b, input cpu_pkg::data_t tgt);
        int r;
        tab_instr[n_added]   = instr;
        tab_regs[n_added][0] = a;
        tab_regs[n_added][1] = b;
        tab_regs[n_added][2] = 16'h0028;               // Target word at 40
        tab_regs[n_added][3] = 16'hff30;               // Word 48, upper bits ignored
        for (r = 4; r < cpu_pkg::reg_count; r++)
            tab_regs[n_added][r] = cpu_pkg::data_t'(r) * 16'h1111;
        tab_tgt[n_added]   = tgt;
        tab_delay[n_added] = 12 + ($unsigned($random(seed)) % 24);  // Up to max_delay
        n_added++;
    endtask

    task automatic load_memory(input int i);
        int a;
        for (a = 0; a < mem_words; a++)
            mem_model[a] = {10'h2d5, cpu_pkg::addr_t'(a)};  // Background depends on address
        for (a = 0; a < cpu_pkg::reg_count; a++)
            mem_model[a] = tab_regs[i][a];
        mem_model[tgt_addr]               = tab_tgt[i];
        mem_model[cpu_pkg::prog_start]     = tab_instr[i];
        mem_model[cpu_pkg::prog_start + 1] = stop_word;
        for (a = 0; a < mem_words; a++)
            exp_mem[a] = mem_model[a];
    endtask

    function automatic cpu_pkg::addr_t operand_addr(input cpu_pkg::operand_t op);
        if (op[cpu_pkg::reg_bits])
            return exp_mem[op[cpu_pkg::reg_bits-1:0]][cpu_pkg::addr_width-1:0];
        return cpu_pkg::addr_t'(op[cpu_pkg::reg_bits-1:0]);
    endfunction

    // Expected memory, out and write count
    task automatic predict(input int i);
        cpu_pkg::mem_word_u iw;
        logic [2:0]         m;
        cpu_pkg::data_t     xv;
        cpu_pkg::data_t     yv;
        cpu_pkg::data_t     res;
        iw.word = tab_instr[i];
        m       = cpu_pkg::op_mask(iw.instr.opc);
        xv      = exp_mem[operand_addr(iw.instr.opx)];
        yv      = exp_mem[operand_addr(iw.instr.opy)];
        case (iw.instr.opc)
            cpu_pkg::op_add: res = xv + yv;
            cpu_pkg::op_sub: res = xv - yv;
            cpu_pkg::op_in:  res = in_data;
            default:         res = xv;
        endcase
        exp_out    = (iw.instr.opc == cpu_pkg::op_out) ? xv : '0;
        exp_writes = m[0];
        if (m[0])
            exp_mem[operand_addr(iw.instr.opz)] = res;
        in_case = (iw.instr.opc == cpu_pkg::op_in);
    endtask

    initial begin
        int i;
        int a;
        int cyc;
        rst_n   = 1'b1;
        control = 1'b0;
        in_data = '0;
        n_added = 0;
        errors  = 0;
        checks  = 0;
        writes  = 0;
        in_case = 1'b0;

        add_case(16'h0005, 16'h1357, 16'h2468, 16'h0bad);  // MOV r0 to r5
        add_case(16'h0a0b, 16'h1357, 16'h2468, 16'h7e57);  // MOV through pointers
        add_case(16'h1014, 16'hffff, 16'h0002, 16'h0000);  // ADD overflow
        add_case(16'h201b, 16'h0001, 16'h0003, 16'h0000);  // SUB underflow
        add_case(16'h20a6, 16'h0010, 16'h0000, 16'h0020);
        add_case(16'h10ab, 16'h8000, 16'h0000, 16'h8000);
        add_case(16'h2a14, 16'h0000, 16'h0007, 16'h0005);
        add_case(16'h1a1b, 16'h0000, 16'h0020, 16'hfff0);
        add_case(16'h2aa4, 16'h0000, 16'h0000, 16'h1234);
        add_case(16'h1aab, 16'h0000, 16'h0000, 16'h7fff);
        add_case(16'h8000, 16'hc0de, 16'h0000, 16'h0000);  // OUT direct
        add_case(16'h8a00, 16'h0000, 16'h0000, 16'hbeef);
        add_case(16'h7006, 16'h0000, 16'h0000, 16'h0000);  // IN to r6
        add_case(16'h700b, 16'h0000, 16'h0000, 16'h0000);
        add_case(16'h3014, 16'h0004, 16'h0005, 16'h0000);  // MUL, no effect
        add_case(16'h4014, 16'h0004, 16'h0005, 16'h0000);

        for (i = 0; i < n_cases; i++) begin
            @(posedge clk);
            rst_n   <= 1'b0;
            control <= 1'b0;
            in_data <= cpu_pkg::data_t'($random(seed));
            load_memory(i);
            writes = 0;
            repeat (4) @(posedge clk);
            check_bit("we", we, 1'b0);
            check_bit("status", status, 1'b0);
            check_word("out", out, '0);
            check_addr("addr", addr, '0);
            check_addr("pc", pc, cpu_pkg::prog_start);
            rst_n <= 1'b1;
            predict(i);
            cyc = 0;
            while (status !== 1'b1) begin
                @(posedge clk);
                cyc++;
                if (cyc == tab_delay[i])
                    control <= 1'b1;
            end
            repeat (3) @(posedge clk);   // Let anything stray show up
            check_bit("status", status, 1'b1);
            check_addr("pc", pc, cpu_pkg::addr_t'(cpu_pkg::prog_start + 2));
            check_word("out", out, exp_out);
            for (a = 0; a < mem_words; a++)
                check_word($sformatf("mem[%0d]", a), mem_model[a], exp_mem[a]);
            if (writes != exp_writes) begin
                errors++;
                $display("Case %0d made %0d memory writes instead of %0d", i, writes, exp_writes);
            end
        end

        props_fails = cpu_top_i.cpu_props_i.fails;
        $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                 checks, errors, props_fails);
        if (errors == 0 && props_fails == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

//--- cpu.f
cpu_pkg.sv
cpu_control.sv
cpu_datapath.sv
cpu_top.sv
cpu_props.sv
cpu_tb.sv
